// ==== Makefile ====
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f msk_alu.f --top-module msk_alu

sim:
	verilator --binary --timing --assert -j 0 -f msk_alu.f --top-module msk_alu_tb \
		-Mdir obj_dir -o sim_msk_alu
	./obj_dir/sim_msk_alu | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/msk_alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module msk_alu_tb;
  import msk_alu_pkg::*;

  localparam int N_TESTS         = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WAIT_LIMIT      = 50;   // Longest wait for one handshake
  localparam int LAT_LOGIC       = 2;
  localparam int LAT_ARITH       = 7;   // Gadget cycle, five rounds, load

  logic      g_clk;
  logic      g_resetn;
  logic      i_valid;
  msk_op_e   i_op;
  msk_word_t i_rs1_s0;
  msk_word_t i_rs1_s1;
  msk_word_t i_rs2_s0;
  msk_word_t i_rs2_s1;
  logic      i_ready;
  logic      o_ready;
  logic      o_valid;
  msk_word_t o_rd_s0;
  msk_word_t o_rd_s1;

  integer seed;
  int     errors;
  int     checks;

  tb_clkgen clkgen_i (
    .o_g_clk    (g_clk),
    .o_g_resetn (g_resetn)
  );

  msk_alu msk_alu_i (
    .i_g_clk    (g_clk),
    .i_g_resetn (g_resetn),
    .i_valid    (i_valid),
    .i_op       (i_op),
    .i_rs1_s0   (i_rs1_s0),
    .i_rs1_s1   (i_rs1_s1),
    .i_rs2_s0   (i_rs2_s0),
    .i_rs2_s1   (i_rs2_s1),
    .o_ready    (o_ready),
    .o_valid    (o_valid),
    .o_rd_s0    (o_rd_s0),
    .o_rd_s1    (o_rd_s1),
    .i_ready    (i_ready)
  );

  task automatic check_word(input string name, input msk_word_t got, input msk_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s latency got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge g_clk);
    #1;
  endtask

  task automatic split(input msk_word_t plain, output msk_word_t s0, output msk_word_t s1);
    msk_word_t m;
    m  = $random(seed);
    s0 = plain ^ m;
    s1 = m;
  endtask

  function automatic msk_word_t logic_ref(input msk_op_e op, input msk_word_t a,
                                          input msk_word_t b);
    case (op)
      MSK_OP_XOR: return a ^ b;
      MSK_OP_AND: return a & b;
      MSK_OP_IOR: return a | b;
      default:    return ~a;   // NOT uses rs1 only
    endcase
  endfunction

  task automatic wait_ready();
    int n;
    n = 0;
    while (o_ready !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (o_ready !== 1'b1) begin
      errors++;
      $display("Timeout at %0t: DUT never raised o_ready", $time);
    end
  endtask

  // Send one request and wait for its result pair
  task automatic run_op(input msk_op_e op, input msk_word_t r1s0, input msk_word_t r1s1,
                        input msk_word_t r2s0, input msk_word_t r2s1, input int exp_lat,
                        output msk_word_t s0, output msk_word_t s1);
    int cycles;
    wait_ready();
    i_valid  = 1'b1;
    i_op     = op;
    i_rs1_s0 = r1s0;
    i_rs1_s1 = r1s1;
    i_rs2_s0 = r2s0;
    i_rs2_s1 = r2s1;
    next_cycle();   // Accept edge
    i_valid = 1'b0;
    cycles  = 0;
    while (o_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (o_valid !== 1'b1) begin
      errors++;
      $display("Timeout at %0t: no result for %s", $time, op.name());
    end else begin
      check_latency(op.name(), cycles, exp_lat);
    end
    s0 = o_rd_s0;
    s1 = o_rd_s1;
  endtask

  task automatic arith_case(input msk_op_e op, input msk_word_t a, input msk_word_t b);
    msk_word_t a0, a1, b0, b1, s0, s1, exp;
    split(a, a0, a1);
    split(b, b0, b1);
    exp = (op == MSK_OP_ADD) ? a + b : a - b;   // Modulo 2^32
    run_op(op, a0, a1, b0, b1, LAT_ARITH, s0, s1);
    check_word($sformatf("%s(%h,%h)", op.name(), a, b), s0 ^ s1, exp);
  endtask

  task automatic test_reset_state();
    repeat (2) @(posedge g_clk);
    #1;
    check_bit("o_valid in reset", o_valid, 1'b0);
    check_bit("o_ready in reset", o_ready, 1'b1);
    wait (g_resetn === 1'b1);
    next_cycle();
    check_bit("o_valid after reset", o_valid, 1'b0);
    check_bit("o_ready after reset", o_ready, 1'b1);
  endtask

  task automatic test_logic_ops();
    msk_op_e   ops [4] = '{MSK_OP_XOR, MSK_OP_AND, MSK_OP_IOR, MSK_OP_NOT};
    msk_word_t a, b, a0, a1, b0, b1, s0, s1;
    for (int rep = 0; rep < 4; rep++) begin
      for (int k = 0; k < 4; k++) begin
        a = $random(seed);
        b = $random(seed);
        split(a, a0, a1);
        split(b, b0, b1);
        run_op(ops[k], a0, a1, b0, b1, LAT_LOGIC, s0, s1);
        check_word($sformatf("%s unmasked", ops[k].name()), s0 ^ s1, logic_ref(ops[k], a, b));
      end
    end
  endtask

  task automatic test_add_sub();
    for (int rep = 0; rep < 6; rep++) begin
      arith_case(MSK_OP_ADD, $random(seed), $random(seed));
      arith_case(MSK_OP_SUB, $random(seed), $random(seed));
    end
    arith_case(MSK_OP_ADD, 32'hFFFF_FFFF, 32'h1);   // Carry out of every bit
    arith_case(MSK_OP_SUB, 32'h0, 32'h1);           // Borrow through every bit
  endtask

  task automatic test_mask_remask();
    msk_word_t plain, x0, x1, s0, s1, r0, r1;
    plain = $random(seed);
    run_op(MSK_OP_MASK, plain, '0, '0, '0, LAT_LOGIC, s0, s1);
    check_word("MASK unmasked", s0 ^ s1, plain);
    check_bit("MASK share 1 nonzero", s1 != '0, 1'b1);
    plain = $random(seed);
    split(plain, x0, x1);
    run_op(MSK_OP_REMASK, x0, x1, '0, '0, LAT_LOGIC, s0, s1);
    check_word("REMASK first unmasked", s0 ^ s1, plain);
    run_op(MSK_OP_REMASK, x0, x1, '0, '0, LAT_LOGIC, r0, r1);
    check_word("REMASK second unmasked", r0 ^ r1, plain);
    check_bit("REMASK fresh share 1", r1 != s1, 1'b1);
  endtask

  task automatic test_back_pressure();
    msk_word_t a, b, a0, a1, b0, b1, s0, s1;
    a = $random(seed);
    b = $random(seed);
    split(a, a0, a1);
    split(b, b0, b1);
    wait_ready();   // Earlier result must drain before the consumer stalls
    i_ready = 1'b0;
    run_op(MSK_OP_AND, a0, a1, b0, b1, LAT_LOGIC, s0, s1);
    repeat (10) begin
      next_cycle();
      check_bit("o_valid held", o_valid, 1'b1);
      check_word("o_rd_s0 held", o_rd_s0, s0);
      check_word("o_rd_s1 held", o_rd_s1, s1);
      check_bit("o_ready while held", o_ready, 1'b0);
    end
    check_word("AND after stall", o_rd_s0 ^ o_rd_s1, a & b);
    i_ready = 1'b1;
    next_cycle();   // Result taken here
    check_bit("o_valid after take", o_valid, 1'b0);
    wait_ready();
  endtask

  initial begin
    seed     = 32'h83cf_6613;
    errors   = 0;
    checks   = 0;
    i_valid  = 1'b0;
    i_op     = MSK_OP_XOR;
    i_rs1_s0 = '0;
    i_rs1_s1 = '0;
    i_rs2_s0 = '0;
    i_rs2_s1 = '0;
    i_ready  = 1'b1;
    test_reset_state();
    test_logic_ops();
    test_add_sub();
    test_mask_remask();
    test_back_pressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (N_TESTS * CYCLES_PER_TEST) @(posedge g_clk);
    $display("Watchdog expired after %0d cycles", N_TESTS * CYCLES_PER_TEST);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic o_g_clk,
  output logic o_g_resetn
);
  localparam int HALF_PERIOD  = 5;   // 10 ns clock
  localparam int RESET_CYCLES = 5;

  initial begin
    o_g_clk = 1'b0;
    forever #HALF_PERIOD o_g_clk = ~o_g_clk;
  end

  // Release lines up with the testbench drive point
  initial begin
    o_g_resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_g_clk);
    #1 o_g_resetn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== msk_alu.f ====
+incdir+verilog
verilog/msk_alu_pkg.sv
verilog/msk_prng.sv
verilog/msk_issue.sv
verilog/msk_pg_stage.sv
verilog/msk_prefix_adder.sv
verilog/msk_result_buf.sv
verilog/msk_alu.sv
dv/tb_clkgen.sv
dv/msk_alu_tb.sv

// ==== verilog/msk_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module msk_alu (
  input  logic                   i_g_clk,
  input  logic                   i_g_resetn,
  input  logic                   i_valid,
  input  msk_alu_pkg::msk_op_e   i_op,
  input  msk_alu_pkg::msk_word_t i_rs1_s0,
  input  msk_alu_pkg::msk_word_t i_rs1_s1,
  input  msk_alu_pkg::msk_word_t i_rs2_s0,
  input  msk_alu_pkg::msk_word_t i_rs2_s1,
  output logic                   o_ready,
  output logic                   o_valid,
  output msk_alu_pkg::msk_word_t o_rd_s0,
  output msk_alu_pkg::msk_word_t o_rd_s1,
  input  logic                   i_ready
);
  import msk_alu_pkg::*;

  logic      accept;
  logic      pg_en;
  logic      add_start;
  logic      sub;
  logic      res_load;
  logic      inv_s1;
  logic      done;
  logic      empty;
  msk_sel_e  sel;
  msk_word_t prng;
  msk_word_t gs;
  msk_word_t a0, a1, b0, b1;
  msk_word_t p0, p1, g0, g1;
  msk_word_t s0, s1;

  msk_prng prng_i (
    .i_g_clk    (i_g_clk),
    .i_g_resetn (i_g_resetn),
    .i_step     (accept),
    .o_prng     (prng)
  );

  msk_issue issue_i (
    .i_g_clk     (i_g_clk),
    .i_g_resetn  (i_g_resetn),
    .i_valid     (i_valid),
    .i_op        (i_op),
    .i_rs1_s0    (i_rs1_s0),
    .i_rs1_s1    (i_rs1_s1),
    .i_rs2_s0    (i_rs2_s0),
    .i_rs2_s1    (i_rs2_s1),
    .i_prng      (prng),
    .i_done      (done),
    .i_empty     (empty),
    .o_ready     (o_ready),
    .o_accept    (accept),
    .o_pg_en     (pg_en),
    .o_a0        (a0),
    .o_a1        (a1),
    .o_b0        (b0),
    .o_b1        (b1),
    .o_gs        (gs),
    .o_add_start (add_start),
    .o_sub       (sub),
    .o_res_load  (res_load),
    .o_sel       (sel),
    .o_inv_s1    (inv_s1)
  );

  msk_pg_stage pg_stage_i (
    .i_g_clk    (i_g_clk),
    .i_g_resetn (i_g_resetn),
    .i_en       (pg_en),
    .i_gs       (gs),
    .i_a0       (a0),
    .i_a1       (a1),
    .i_b0       (b0),
    .i_b1       (b1),
    .o_p0       (p0),
    .o_p1       (p1),
    .o_g0       (g0),
    .o_g1       (g1)
  );

  msk_prefix_adder adder_i (
    .i_g_clk    (i_g_clk),
    .i_g_resetn (i_g_resetn),
    .i_start    (add_start),
    .i_sub      (sub),
    .i_gs       (gs),
    .i_p0       (p0),
    .i_p1       (p1),
    .i_g0       (g0),
    .i_g1       (g1),
    .o_s0       (s0),
    .o_s1       (s1),
    .o_done     (done)
  );

  // XOR pair doubles as the mask and remask result
  msk_result_buf result_buf_i (
    .i_g_clk    (i_g_clk),
    .i_g_resetn (i_g_resetn),
    .i_load     (res_load),
    .i_sel      (sel),
    .i_inv_s1   (inv_s1),
    .i_xor0     (p0),
    .i_xor1     (p1),
    .i_and0     (g0),
    .i_and1     (g1),
    .i_add0     (s0),
    .i_add1     (s1),
    .i_ready    (i_ready),
    .o_valid    (o_valid),
    .o_rd_s0    (o_rd_s0),
    .o_rd_s1    (o_rd_s1),
    .o_empty    (empty)
  );

endmodule

`default_nettype wire

// ==== verilog/msk_alu_defs.svh ====
`ifndef MSK_ALU_DEFS_SVH
`define MSK_ALU_DEFS_SVH

// Width of one share
`define MSK_XLEN 32

`define MSK_PRNG_SEED 32'h6789ABCD

// One prefix round per doubling of the carry span
`define MSK_ADD_ROUNDS 5

// Feedback taps of the XNOR LFSR
`define MSK_LFSR_TAP0 31
`define MSK_LFSR_TAP1 21
`define MSK_LFSR_TAP2 1
`define MSK_LFSR_TAP3 0

`endif

// ==== verilog/msk_alu_pkg.sv ====
`default_nettype none

package msk_alu_pkg;

  `include "msk_alu_defs.svh"

  typedef logic [`MSK_XLEN-1:0] msk_word_t;   // One share of a masked word

  typedef enum logic [2:0] {
    MSK_OP_XOR,
    MSK_OP_AND,
    MSK_OP_IOR,
    MSK_OP_NOT,
    MSK_OP_ADD,
    MSK_OP_SUB,
    MSK_OP_MASK,
    MSK_OP_REMASK
  } msk_op_e;

  // Which gadget output pair becomes the result
  typedef enum logic [1:0] {
    MSK_SEL_XOR,
    MSK_SEL_AND,
    MSK_SEL_ADD
  } msk_sel_e;

endpackage

`default_nettype wire

// ==== verilog/msk_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module msk_issue (
  input  logic                   i_g_clk,
  input  logic                   i_g_resetn,
  input  logic                   i_valid,
  input  msk_alu_pkg::msk_op_e   i_op,
  input  msk_alu_pkg::msk_word_t i_rs1_s0,
  input  msk_alu_pkg::msk_word_t i_rs1_s1,
  input  msk_alu_pkg::msk_word_t i_rs2_s0,
  input  msk_alu_pkg::msk_word_t i_rs2_s1,
  input  msk_alu_pkg::msk_word_t i_prng,
  input  logic                   i_done,
  input  logic                   i_empty,
  output logic                   o_ready,
  output logic                   o_accept,
  output logic                   o_pg_en,
  output msk_alu_pkg::msk_word_t o_a0,
  output msk_alu_pkg::msk_word_t o_a1,
  output msk_alu_pkg::msk_word_t o_b0,
  output msk_alu_pkg::msk_word_t o_b1,
  output msk_alu_pkg::msk_word_t o_gs,
  output logic                   o_add_start,
  output logic                   o_sub,
  output logic                   o_res_load,
  output msk_alu_pkg::msk_sel_e  o_sel,
  output logic                   o_inv_s1
);
  import msk_alu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOGIC,   // Gadget stage fires
    S_ARITH,   // Prefix rounds running
    S_WAIT     // Result sits in the output buffer
  } state_e;

  state_e    state_q;
  msk_op_e   op_q;
  logic      pg_en_q;   // Gadget stage fired in the previous cycle
  logic      arith;
  msk_word_t a1_d;
  msk_word_t b0_d;
  msk_word_t b1_d;

  assign o_ready  = (state_q == S_IDLE);
  assign o_accept = i_valid && o_ready;
  assign o_pg_en  = (state_q == S_LOGIC);
  assign o_gs     = i_prng;   // LFSR has already stepped past the mask word

  assign arith    = (op_q == MSK_OP_ADD) || (op_q == MSK_OP_SUB);
  assign o_sub    = (op_q == MSK_OP_SUB);
  assign o_inv_s1 = (op_q == MSK_OP_NOT) || (op_q == MSK_OP_IOR);

  assign o_add_start = (state_q == S_ARITH) && pg_en_q;
  assign o_res_load  = ((state_q == S_WAIT) && pg_en_q) || ((state_q == S_ARITH) && i_done);

  always_comb begin
    case (op_q)
      MSK_OP_AND, MSK_OP_IOR: o_sel = MSK_SEL_AND;
      MSK_OP_ADD, MSK_OP_SUB: o_sel = MSK_SEL_ADD;
      default:                o_sel = MSK_SEL_XOR;
    endcase
  end

  // Complementing share 1 turns OR into AND (De Morgan) and B into ~B for SUB
  always_comb begin
    a1_d = i_rs1_s1;
    b0_d = i_rs2_s0;
    b1_d = i_rs2_s1;
    case (i_op)
      MSK_OP_IOR: begin
        a1_d = ~i_rs1_s1;
        b1_d = ~i_rs2_s1;
      end
      MSK_OP_SUB: b1_d = ~i_rs2_s1;
      MSK_OP_NOT: begin
        b0_d = '0;   // XOR with zero, inversion happens at the output
        b1_d = '0;
      end
      MSK_OP_MASK: begin
        a1_d = '0;   // Plain word sits in share 0
        b0_d = i_prng;
        b1_d = i_prng;
      end
      MSK_OP_REMASK: begin
        b0_d = i_prng;
        b1_d = i_prng;
      end
      default: ;
    endcase
  end

  // Operand shares for the gadget stage
  always_ff @(posedge i_g_clk) begin
    if (o_accept) begin
      o_a0 <= i_rs1_s0;
      o_a1 <= a1_d;
      o_b0 <= b0_d;
      o_b1 <= b1_d;
    end
  end

  always_ff @(posedge i_g_clk) begin
    if (!i_g_resetn) begin
      state_q <= S_IDLE;
      op_q    <= MSK_OP_XOR;
      pg_en_q <= 1'b0;
    end else begin
      pg_en_q <= o_pg_en;
      if (o_accept) op_q <= i_op;
      case (state_q)
        S_IDLE:  if (o_accept) state_q <= S_LOGIC;
        S_LOGIC: state_q <= arith ? S_ARITH : S_WAIT;
        S_ARITH: if (i_done) state_q <= S_WAIT;
        default: if (i_empty && !pg_en_q) state_q <= S_IDLE;   // Result taken
      endcase
    end
  end

  // A new request only enters an idle unit with a drained result buffer
  a_accept_idle : assert property (@(posedge i_g_clk) disable iff (!i_g_resetn)
    o_accept |-> (state_q == S_IDLE) && i_empty ##1 o_pg_en);

endmodule

`default_nettype wire

// ==== verilog/msk_pg_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msk_alu_defs.svh"

module msk_pg_stage (
  input  logic                   i_g_clk,
  input  logic                   i_g_resetn,
  input  logic                   i_en,
  input  msk_alu_pkg::msk_word_t i_gs,
  input  msk_alu_pkg::msk_word_t i_a0,
  input  msk_alu_pkg::msk_word_t i_a1,
  input  msk_alu_pkg::msk_word_t i_b0,
  input  msk_alu_pkg::msk_word_t i_b1,
  output msk_alu_pkg::msk_word_t o_p0,
  output msk_alu_pkg::msk_word_t o_p1,
  output msk_alu_pkg::msk_word_t o_g0,
  output msk_alu_pkg::msk_word_t o_g1
);

  // One gadget per bit: share-wise XOR and a registered threshold AND
  for (genvar i = 0; i < `MSK_XLEN; i++) begin : g_bit
    logic       p0_q;
    logic       p1_q;
    logic [3:0] t_q;   // Cross products, recombined only after the register

    always_ff @(posedge i_g_clk) begin
      if (!i_g_resetn) begin
        p0_q <= 1'b0;
        p1_q <= 1'b0;
        t_q  <= 4'b0;
      end else if (i_en) begin
        p0_q   <= i_a0[i] ^ i_b0[i];
        p1_q   <= i_a1[i] ^ i_b1[i];
        t_q[0] <= i_gs[i] ^ (i_a0[i] & i_b0[i]);   // Guard bit hides share 0 terms
        t_q[1] <= i_gs[i] ^ (i_a0[i] & i_b1[i]);
        t_q[2] <= i_a1[i] & i_b0[i];
        t_q[3] <= i_a1[i] & i_b1[i];
      end
    end

    assign o_p0[i] = p0_q;
    assign o_p1[i] = p1_q;
    assign o_g0[i] = t_q[0] ^ t_q[2];
    assign o_g1[i] = t_q[1] ^ t_q[3];
  end

endmodule

`default_nettype wire

// ==== verilog/msk_prefix_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msk_alu_defs.svh"

module msk_prefix_adder (
  input  logic                   i_g_clk,
  input  logic                   i_g_resetn,
  input  logic                   i_start,
  input  logic                   i_sub,
  input  msk_alu_pkg::msk_word_t i_gs,
  input  msk_alu_pkg::msk_word_t i_p0,
  input  msk_alu_pkg::msk_word_t i_p1,
  input  msk_alu_pkg::msk_word_t i_g0,
  input  msk_alu_pkg::msk_word_t i_g1,
  output msk_alu_pkg::msk_word_t o_s0,
  output msk_alu_pkg::msk_word_t o_s1,
  output logic                   o_done
);
  import msk_alu_pkg::*;

  logic [2:0] rnd_q;     // Rounds completed
  logic [2:0] rnd_idx;
  logic [5:0] sh;        // Span of the current round
  logic       step;
  msk_word_t  pk0, pk1, gk0, gk1;
  msk_word_t  pj0, pj1, gj0, gj1;
  msk_word_t  cin_vec;
  msk_word_t  tg0_q, tg1_q, tg2_q, tg3_q;
  msk_word_t  tp0_q, tp1_q, tp2_q, tp3_q;
  msk_word_t  p0_r, p1_r, g0_r, g1_r;

  assign o_done  = (rnd_q == 3'(`MSK_ADD_ROUNDS));
  assign step    = i_start || ((rnd_q != 3'd0) && !o_done);
  assign rnd_idx = i_start ? 3'd0 : rnd_q;
  assign sh      = 6'd1 << rnd_idx;   // 1, 2, 4, 8, 16

  always_ff @(posedge i_g_clk) begin
    if (!i_g_resetn) begin
      rnd_q <= 3'd0;
    end else if (o_done) begin
      rnd_q <= 3'd0;
    end else if (step) begin
      rnd_q <= rnd_q + 3'd1;
    end
  end

  // First round reads the gadget stage, later ones the round state
  assign pk0 = i_start ? i_p0 : p0_r;
  assign pk1 = i_start ? i_p1 : p1_r;
  assign gk0 = i_start ? i_g0 : g0_r;
  assign gk1 = i_start ? i_g1 : g1_r;

  // Carry-in acts as a generate just below bit 0
  assign cin_vec = {{(`MSK_XLEN-1){1'b0}}, i_sub} << (sh - 6'd1);

  assign pj0 = pk0 << sh;
  assign pj1 = pk1 << sh;
  assign gj0 = gk0 << sh;
  assign gj1 = (gk1 << sh) | cin_vec;

  // G' = G ^ (P & Gj) and P' = P & Pj, each split into four registered terms
  always_ff @(posedge i_g_clk) begin
    if (step) begin
      tg0_q <= gk0 ^ (gj0 & pk0);
      tg1_q <= gk1 ^ (gj1 & pk0);
      tg2_q <= gj0 & pk1;
      tg3_q <= gj1 & pk1;
      tp0_q <= i_gs ^ (pk0 & pj0);
      tp1_q <= i_gs ^ (pk0 & pj1);
      tp2_q <= pk1 & pj0;
      tp3_q <= pk1 & pj1;
    end
  end

  assign g0_r = tg0_q ^ tg2_q;
  assign g1_r = tg1_q ^ tg3_q;
  assign p0_r = tp0_q ^ tp2_q;
  assign p1_r = tp1_q ^ tp3_q;

  // Sum is the original propagate XOR the carries into each bit
  assign o_s0 = i_p0 ^ (g0_r << 1);
  assign o_s1 = i_p1 ^ {g1_r[`MSK_XLEN-2:0], i_sub};

  // Bounded count, and a new start only on an idle counter
  a_rnd_bound : assert property (@(posedge i_g_clk) disable iff (!i_g_resetn)
    (rnd_q <= 3'(`MSK_ADD_ROUNDS)) && (!i_start || (rnd_q == 3'd0)));

  // Done follows start by exactly the round count
  a_start_done : assert property (@(posedge i_g_clk) disable iff (!i_g_resetn)
    i_start |-> ##(`MSK_ADD_ROUNDS) o_done);

endmodule

`default_nettype wire

// ==== verilog/msk_prng.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "msk_alu_defs.svh"

module msk_prng (
  input  logic                   i_g_clk,
  input  logic                   i_g_resetn,
  input  logic                   i_step,
  output msk_alu_pkg::msk_word_t o_prng
);
  import msk_alu_pkg::*;

  msk_word_t lfsr_q;
  logic      fb;

  // Fibonacci feedback, XNOR form so all-zero is a legal state
  assign fb = lfsr_q[`MSK_LFSR_TAP0] ~^ lfsr_q[`MSK_LFSR_TAP1] ~^
              lfsr_q[`MSK_LFSR_TAP2] ~^ lfsr_q[`MSK_LFSR_TAP3];

  always_ff @(posedge i_g_clk) begin
    if (!i_g_resetn) begin
      lfsr_q <= `MSK_PRNG_SEED;
    end else if (i_step) begin
      lfsr_q <= {lfsr_q[`MSK_XLEN-2:0], fb};
    end
  end

  assign o_prng = lfsr_q;

endmodule

`default_nettype wire

// ==== verilog/msk_result_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module msk_result_buf (
  input  logic                   i_g_clk,
  input  logic                   i_g_resetn,
  input  logic                   i_load,
  input  msk_alu_pkg::msk_sel_e  i_sel,
  input  logic                   i_inv_s1,
  input  msk_alu_pkg::msk_word_t i_xor0,
  input  msk_alu_pkg::msk_word_t i_xor1,
  input  msk_alu_pkg::msk_word_t i_and0,
  input  msk_alu_pkg::msk_word_t i_and1,
  input  msk_alu_pkg::msk_word_t i_add0,
  input  msk_alu_pkg::msk_word_t i_add1,
  input  logic                   i_ready,
  output logic                   o_valid,
  output msk_alu_pkg::msk_word_t o_rd_s0,
  output msk_alu_pkg::msk_word_t o_rd_s1,
  output logic                   o_empty
);
  import msk_alu_pkg::*;

  msk_word_t sel0;
  msk_word_t sel1;

  always_comb begin
    case (i_sel)
      MSK_SEL_XOR: begin
        sel0 = i_xor0;
        sel1 = i_xor1;
      end
      MSK_SEL_AND: begin
        sel0 = i_and0;
        sel1 = i_and1;
      end
      default: begin
        sel0 = i_add0;
        sel1 = i_add1;
      end
    endcase
  end

  always_ff @(posedge i_g_clk) begin
    if (!i_g_resetn) begin
      o_valid <= 1'b0;
    end else if (i_load) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;   // Taken by the consumer
    end
  end

  always_ff @(posedge i_g_clk) begin
    if (i_load) begin
      o_rd_s0 <= sel0;
      o_rd_s1 <= i_inv_s1 ? ~sel1 : sel1;   // Inverting one share inverts the value
    end
  end

  assign o_empty = !o_valid;

  a_hold : assert property (@(posedge i_g_clk) disable iff (!i_g_resetn)
    o_valid && !i_ready |=> o_valid && $stable(o_rd_s0) && $stable(o_rd_s1));

endmodule

`default_nettype wire
